//--- Makefile
VERILATOR ?= verilator
TOP       ?= pet_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Test passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST))) $(wildcard logic/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Pass only if the log holds the pass line
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/pet_sva.sv
// Rules on the FSM state and the registered outputs
module pet_sva (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      touring,
    input  logic                      step_seen,
    input  pet_state_pkg::phase_e     phase,
    input  pet_state_pkg::tour_pos_t  tour_pos,
    input  pet_io_pkg::display_code_t display,
    input  pet_io_pkg::enable_vec_t   enables
);
    timeunit 1ns;
    timeprecision 1ps;

    // Actuators go off one clk into the tour
    touring_clears_enables: assert property (
        @(posedge clk) disable iff (!reset)
        touring |=> (enables == '0)
    ) else $error("Enables still set one clk after touring");

    idle_blanks_display: assert property (
        @(posedge clk) disable iff (!reset)
        (phase == pet_state_pkg::IDLE) |=> (display == '0)
    ) else $error("Display not blank one clk after idle");

    // Counter and pulse come from the same edge
    tour_pos_moves_on_step: assert property (
        @(posedge clk) disable iff (!reset)
        (tour_pos != $past(tour_pos)) |-> step_seen
    ) else $error("Tour position changed without a step");

endmodule

//--- bench/pet_tb.sv
`include "pet_consts.svh"

module pet_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_HALF       = 10;
    localparam int DRIVE_DELAY    = 2;
    localparam int RESET_CYCLES   = 10;
    localparam int SETTLE_CLKS    = 4;     // Level or care change to outputs
    localparam int STEP_CLKS      = 8;     // Step edge to outputs
    localparam int STEP_LOW_CLKS  = 4;
    localparam int PRIORITY_DRAWS = 8;

    localparam int PH_IDLE = 0;
    localparam int PH_WARN = 1;
    localparam int PH_CRIT = 2;
    localparam int PH_CARE = 3;

    localparam pet_io_pkg::level_t FULL = 2'd3;
    localparam logic [31:0] LFSR_SEED = 32'hbbb7;
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    // Rough cycle budget per test, four times over
    localparam int TEST_CYCLES = RESET_CYCLES + 30 + PRIORITY_DRAWS * 24 + 48
                                 + `PET_TOUR_LEN * 13 + 12;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic                      clk;
    logic                      reset;
    pet_io_pkg::level_t        food_level;
    pet_io_pkg::level_t        health_level;
    pet_io_pkg::level_t        rest_level;
    pet_io_pkg::level_t        mood_level;
    logic                      food_button;
    logic                      medicine_button;
    logic                      light_sensor;
    logic                      ultrasonic_sensor;
    logic                      test_mode;
    logic                      test_step;
    pet_io_pkg::display_code_t display;
    logic                      food_enable;
    logic                      medicine_enable;
    logic                      light_enable;
    logic                      ultrasonic_enable;
    pet_io_pkg::enable_vec_t   enables;

    int          error_count  = 0;
    int          check_count  = 0;
    int          test_count   = 0;
    int          failed_tests = 0;
    int          cycle_count  = 0;
    logic [31:0] lfsr_state;

    assign enables = {ultrasonic_enable, light_enable, medicine_enable, food_enable};

    pet_top UUT (
        .clk               (clk),
        .reset             (reset),
        .food_level        (food_level),
        .health_level      (health_level),
        .rest_level        (rest_level),
        .mood_level        (mood_level),
        .food_button       (food_button),
        .medicine_button   (medicine_button),
        .light_sensor      (light_sensor),
        .ultrasonic_sensor (ultrasonic_sensor),
        .test_mode         (test_mode),
        .test_step         (test_step),
        .display           (display),
        .food_enable       (food_enable),
        .medicine_enable   (medicine_enable),
        .light_enable      (light_enable),
        .ultrasonic_enable (ultrasonic_enable)
    );

    bind pet_top pet_sva u_pet_sva (
        .clk       (clk),
        .reset     (reset),
        .touring   (touring),
        .step_seen (step_seen),
        .phase     (phase),
        .tour_pos  (tour_pos),
        .display   (display),
        .enables   (enables)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) cycle_count <= cycle_count + 1;

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failed");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // One LFSR step per bit
    function automatic logic [3:0] draw_bits(input int count);
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < count; i++) begin
            v          = {v[2:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return v;
    endfunction

    // 0 when idle, else 3 codes per need
    function automatic pet_io_pkg::display_code_t expected_code(input int n, input int p);
        if (p == PH_IDLE) begin
            return '0;
        end
        return pet_io_pkg::display_code_t'(3 * n + p);
    endfunction

    task automatic wait_clks(input int n);
        repeat (n) @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic set_levels(input pet_io_pkg::level_t f, input pet_io_pkg::level_t h,
                              input pet_io_pkg::level_t r, input pet_io_pkg::level_t m);
        food_level   = f;
        health_level = h;
        rest_level   = r;
        mood_level   = m;
    endtask

    task automatic set_care(input pet_io_pkg::care_vec_t c);
        food_button       = c[0];
        medicine_button   = c[1];
        light_sensor      = c[2];
        ultrasonic_sensor = c[3];
    endtask

    task automatic check_display(input string name, input pet_io_pkg::display_code_t exp);
        check_count++;
        if (display !== exp) begin
            error_count++;
            $display("ERR %s display: expected %0d, actual %0d", name, exp, display);
        end
    endtask

    task automatic check_enables(input string name, input pet_io_pkg::enable_vec_t exp);
        check_count++;
        if (enables !== exp) begin
            error_count++;
            $display("ERR %s enables: expected %b, actual %b", name, exp, enables);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("%s: ok", name);
        end else begin
            failed_tests++;
            $display("%s: %0d errors", name, error_count - errs_before);
        end
    endtask

    task automatic test_reset_state();
        int errs_before;
        errs_before = error_count;
        // No clk edge since release, outputs still hold their reset values
        check_display("reset_state", expected_code(0, PH_IDLE));
        check_enables("reset_state", '1);
        wait_clks(SETTLE_CLKS);
        check_display("reset_state", expected_code(0, PH_IDLE));
        check_enables("reset_state", '1);
        report_test("reset_state", errs_before);
    endtask

    task automatic test_food_path();
        int errs_before;
        errs_before = error_count;
        set_levels(2'd2, FULL, FULL, FULL);
        wait_clks(SETTLE_CLKS);
        check_display("food_path", expected_code(0, PH_WARN));
        check_enables("food_path", '1);
        food_level = 2'd0;
        wait_clks(SETTLE_CLKS);
        check_display("food_path", expected_code(0, PH_CRIT));
        set_care(4'b0001);
        wait_clks(SETTLE_CLKS);
        check_display("food_path", expected_code(0, PH_CARE));
        check_enables("food_path", '0);
        food_level = FULL;                  // Button still held
        wait_clks(SETTLE_CLKS);
        check_display("food_path", expected_code(0, PH_CARE));
        set_care(4'b0000);
        wait_clks(SETTLE_CLKS);
        check_display("food_path", expected_code(0, PH_IDLE));
        check_enables("food_path", '1);
        report_test("food_path", errs_before);
    endtask

    task automatic test_priority();
        int                      errs_before;
        int                      first;
        int                      other;
        logic [3:0]              bits;
        pet_io_pkg::level_t      levels [`PET_NUM_NEEDS];
        pet_io_pkg::care_vec_t   care;
        errs_before = error_count;
        for (int draw = 0; draw < PRIORITY_DRAWS; draw++) begin
            for (int i = 0; i < `PET_NUM_NEEDS; i++) begin
                bits      = draw_bits(2);
                levels[i] = bits[1:0];
            end
            first = -1;
            for (int i = `PET_NUM_NEEDS - 1; i >= 0; i--) begin
                if (levels[i] != FULL) first = i;
            end
            if (first < 0) begin
                bits          = draw_bits(2);
                first         = int'(bits[1:0]);
                levels[first] = 2'd1;
            end
            // A zero would move on to critical
            if (levels[first] == 2'd0) levels[first] = 2'd1;

            set_levels(levels[0], levels[1], levels[2], levels[3]);
            wait_clks(SETTLE_CLKS);
            check_display("priority", expected_code(first, PH_WARN));
            check_enables("priority", '1);

            if (first < `PET_NUM_NEEDS - 1) begin
                bits        = draw_bits(2);
                other       = first + 1 + int'(bits[1:0]) % (`PET_NUM_NEEDS - 1 - first);
                care        = '0;
                care[other] = 1'b1;
                set_care(care);
                wait_clks(SETTLE_CLKS);
                check_display("priority", expected_code(first, PH_WARN));
            end

            // Care for the shown need to get back to idle
            set_levels(FULL, FULL, FULL, FULL);
            care        = '0;
            care[first] = 1'b1;
            set_care(care);
            wait_clks(SETTLE_CLKS);
            check_display("priority", expected_code(first, PH_CARE));
            set_care('0);
            wait_clks(SETTLE_CLKS);
            check_display("priority", expected_code(0, PH_IDLE));
        end
        report_test("priority", errs_before);
    endtask

    task automatic test_care_fallback();
        int errs_before;
        errs_before = error_count;
        set_levels(FULL, 2'd1, FULL, FULL);
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(1, PH_WARN));
        set_care(4'b0010);
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(1, PH_CARE));
        check_enables("care_fallback", '0);
        set_care(4'b0000);                  // Released at level 1
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(1, PH_WARN));
        check_enables("care_fallback", '1);
        set_care(4'b0010);
        wait_clks(SETTLE_CLKS);
        health_level = 2'd0;
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(1, PH_CARE));
        set_care(4'b0000);                  // Released at level 0
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(1, PH_CRIT));
        check_enables("care_fallback", '1);
        health_level = FULL;
        set_care(4'b0010);
        wait_clks(SETTLE_CLKS);
        set_care(4'b0000);
        wait_clks(SETTLE_CLKS);
        check_display("care_fallback", expected_code(0, PH_IDLE));
        report_test("care_fallback", errs_before);
    endtask

    task automatic test_tour();
        int errs_before;
        int t;
        errs_before = error_count;
        test_mode = 1'b1;
        wait_clks(SETTLE_CLKS);
        check_display("tour", expected_code(0, PH_IDLE));
        check_enables("tour", '0);
        // Counter starts at 0, nothing stepped it before
        for (int s = 1; s <= `PET_TOUR_LEN; s++) begin
            t = s % `PET_TOUR_LEN;
            test_step = 1'b1;
            wait_clks(STEP_CLKS);
            check_display("tour", expected_code(t / 4, t % 4));
            check_enables("tour", '0);
            test_step = 1'b0;
            wait_clks(STEP_LOW_CLKS);
        end
        test_mode = 1'b0;
        set_levels(FULL, FULL, FULL, FULL);
        wait_clks(SETTLE_CLKS);
        check_display("tour", expected_code(0, PH_IDLE));
        check_enables("tour", '1);
        report_test("tour", errs_before);
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        reset      = 1'b0;
        test_mode  = 1'b0;
        test_step  = 1'b0;
        set_levels(FULL, FULL, FULL, FULL);
        set_care('0);
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        reset = 1'b1;

        test_reset_state();
        test_food_path();
        test_priority();
        test_care_fallback();
        test_tour();

        $display("Tests: %0d, failed: %0d, checks: %0d, errors: %0d",
                 test_count, failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+logic
logic/pet_io_pkg.sv
logic/pet_state_pkg.sv
logic/need_bus_if.sv
logic/tour_stepper.sv
logic/pet_fsm.sv
logic/status_outputs.sv
logic/pet_top.sv
bench/pet_sva.sv
bench/pet_tb.sv

//--- logic/need_bus_if.sv
`include "pet_consts.svh"

// Held levels and care inputs, sampled every clk
interface need_bus_if;

    pet_io_pkg::level_t    level [`PET_NUM_NEEDS];
    pet_io_pkg::care_vec_t care;    // Bit n cares for need n

    modport source (
        output level,
        output care
    );

    modport sink (
        input level,
        input care
    );

endinterface

//--- logic/pet_consts.svh
`ifndef PET_CONSTS_SVH
`define PET_CONSTS_SVH

// Need inputs, in priority order food, health, rest, mood
`define PET_NUM_NEEDS 4

// Level encoding, 2 bits per need
`define PET_LEVEL_FULL 3
`define PET_LEVEL_EMPTY 0

// Test tour walks every need/phase pair once
`define PET_TOUR_LEN 16

// Flops on the step button before edge detection
`define PET_SYNC_STAGES 2

// Display codes
`define PET_CODE_IDLE 0
`define PET_CODE_STRIDE 3     // Codes per need (WARN, CRITICAL, CARE)

`endif

//--- logic/pet_fsm.sv
`include "pet_consts.svh"

module pet_fsm (
    input  logic                     clk,
    input  logic                     reset,
    need_bus_if.sink                 needs,
    input  logic                     test_mode,
    input  logic                     step_seen,
    input  pet_state_pkg::tour_pos_t tour_pos,
    output pet_state_pkg::need_e     need,
    output pet_state_pkg::phase_e    phase,
    output logic                     touring
);

    pet_state_pkg::need_e  need_d;
    pet_state_pkg::phase_e phase_d;
    pet_io_pkg::level_t    cur_level;
    logic                  cur_care;

    // Level and care input of the need being shown
    assign cur_level = needs.level[need];
    assign cur_care  = needs.care[need];

    always_comb begin
        need_d  = need;
        phase_d = phase;

        if (test_mode) begin
            // Tour position names the state directly
            if (step_seen) begin
                need_d  = pet_state_pkg::need_e'(tour_pos[3:2]);
                phase_d = pet_state_pkg::phase_e'(tour_pos[1:0]);
            end
        end else begin
            case (phase)
                pet_state_pkg::IDLE: begin
                    // Scan from lowest priority so food wins
                    for (int i = `PET_NUM_NEEDS - 1; i >= 0; i--) begin
                        if (needs.level[i] < `PET_LEVEL_FULL) begin
                            need_d  = pet_state_pkg::need_e'(i[1:0]);
                            phase_d = pet_state_pkg::WARN;
                        end
                    end
                end

                pet_state_pkg::WARN: begin
                    if (cur_level == `PET_LEVEL_EMPTY) begin
                        phase_d = pet_state_pkg::CRITICAL;
                    end else if (cur_care) begin
                        phase_d = pet_state_pkg::CARE;
                    end
                end

                pet_state_pkg::CRITICAL: begin
                    if (cur_care) begin
                        phase_d = pet_state_pkg::CARE;
                    end
                end

                pet_state_pkg::CARE: begin
                    if (cur_care) begin
                        phase_d = pet_state_pkg::CARE;    // Still caring
                    end else if (cur_level == `PET_LEVEL_FULL) begin
                        phase_d = pet_state_pkg::IDLE;
                    end else if (cur_level != `PET_LEVEL_EMPTY) begin
                        phase_d = pet_state_pkg::WARN;
                    end else begin
                        phase_d = pet_state_pkg::CRITICAL;
                    end
                end

                default: begin
                    phase_d = pet_state_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            need    <= pet_state_pkg::FOOD;
            phase   <= pet_state_pkg::IDLE;
            touring <= 1'b0;
        end else begin
            need    <= need_d;
            phase   <= phase_d;
            touring <= test_mode;
        end
    end

endmodule

//--- logic/pet_io_pkg.sv
`include "pet_consts.svh"

// Values crossing the top-level ports
package pet_io_pkg;

    // One need level, 3 is full
    typedef logic [1:0] level_t;

    // Display code
    typedef logic [3:0] display_code_t;

    // Bit 0 food, 1 medicine, 2 light, 3 ultrasonic
    typedef logic [`PET_NUM_NEEDS-1:0] enable_vec_t;

    // Care inputs, same bit order as the enables
    typedef logic [`PET_NUM_NEEDS-1:0] care_vec_t;

endpackage

//--- logic/pet_state_pkg.sv
`include "pet_consts.svh"

// Internal pet state
package pet_state_pkg;

    // Encoding doubles as the index into the need bus
    typedef enum logic [1:0] {
        FOOD   = 2'd0,
        HEALTH = 2'd1,
        REST   = 2'd2,
        MOOD   = 2'd3
    } need_e;

    // Phase of the current need; IDLE means no need is being shown
    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        WARN     = 2'd1,
        CRITICAL = 2'd2,
        CARE     = 2'd3
    } phase_e;

    // Upper bits pick the need, lower bits the phase
    typedef logic [$clog2(`PET_TOUR_LEN)-1:0] tour_pos_t;

endpackage

//--- logic/pet_top.sv
module pet_top (
    input  logic                      clk,
    input  logic                      reset,
    input  pet_io_pkg::level_t        food_level,
    input  pet_io_pkg::level_t        health_level,
    input  pet_io_pkg::level_t        rest_level,
    input  pet_io_pkg::level_t        mood_level,
    input  logic                      food_button,
    input  logic                      medicine_button,
    input  logic                      light_sensor,
    input  logic                      ultrasonic_sensor,
    input  logic                      test_mode,
    input  logic                      test_step,
    output pet_io_pkg::display_code_t display,
    output logic                      food_enable,
    output logic                      medicine_enable,
    output logic                      light_enable,
    output logic                      ultrasonic_enable
);

    need_bus_if needs ();

    logic                     step_seen;
    pet_state_pkg::tour_pos_t tour_pos;
    pet_state_pkg::need_e     need;
    pet_state_pkg::phase_e    phase;
    logic                     touring;
    pet_io_pkg::enable_vec_t  enables;

    // Bus order follows need priority
    assign needs.level[0] = food_level;
    assign needs.level[1] = health_level;
    assign needs.level[2] = rest_level;
    assign needs.level[3] = mood_level;
    assign needs.care     = {ultrasonic_sensor, light_sensor, medicine_button, food_button};

    tour_stepper u_tour_stepper (
        .clk       (clk),
        .reset     (reset),
        .test_mode (test_mode),
        .test_step (test_step),
        .step_seen (step_seen),
        .tour_pos  (tour_pos)
    );

    pet_fsm u_pet_fsm (
        .clk       (clk),
        .reset     (reset),
        .needs     (needs.sink),
        .test_mode (test_mode),
        .step_seen (step_seen),
        .tour_pos  (tour_pos),
        .need      (need),
        .phase     (phase),
        .touring   (touring)
    );

    status_outputs u_status_outputs (
        .clk     (clk),
        .reset   (reset),
        .need    (need),
        .phase   (phase),
        .touring (touring),
        .display (display),
        .enables (enables)
    );

    assign food_enable       = enables[0];
    assign medicine_enable   = enables[1];
    assign light_enable      = enables[2];
    assign ultrasonic_enable = enables[3];

endmodule

//--- logic/status_outputs.sv
`include "pet_consts.svh"

module status_outputs (
    input  logic                       clk,
    input  logic                       reset,
    input  pet_state_pkg::need_e       need,
    input  pet_state_pkg::phase_e      phase,
    input  logic                       touring,
    output pet_io_pkg::display_code_t  display,
    output pet_io_pkg::enable_vec_t    enables
);

    pet_io_pkg::display_code_t code_d;
    logic                      hold_off;

    // Three codes per need, phase picks one
    always_comb begin
        if (phase == pet_state_pkg::IDLE) begin
            code_d = pet_io_pkg::display_code_t'(`PET_CODE_IDLE);
        end else begin
            code_d = pet_io_pkg::display_code_t'(`PET_CODE_STRIDE * need + phase);
        end
    end

    // Actuators off while being cared for or touring
    assign hold_off = (phase == pet_state_pkg::CARE) || touring;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            display <= pet_io_pkg::display_code_t'(`PET_CODE_IDLE);
            enables <= '1;
        end else begin
            display <= code_d;
            if (hold_off) begin
                enables <= '0;
            end else begin
                enables <= '1;
            end
        end
    end

endmodule

//--- logic/tour_stepper.sv
`include "pet_consts.svh"

module tour_stepper (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     test_mode,
    input  logic                     test_step,
    output logic                     step_seen,
    output pet_state_pkg::tour_pos_t tour_pos
);

    logic [`PET_SYNC_STAGES-1:0] step_sync;
    logic                        step_prev;
    logic                        step_rise;

    // Rising edge of the synchronized button
    assign step_rise = step_sync[`PET_SYNC_STAGES-1] & ~step_prev;

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_sync <= '0;
            step_prev <= 1'b0;
        end else begin
            step_sync <= {step_sync[`PET_SYNC_STAGES-2:0], test_step};
            step_prev <= step_sync[`PET_SYNC_STAGES-1];
        end
    end

    // Count holds its value outside test mode
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            step_seen <= 1'b0;
            tour_pos  <= '0;
        end else begin
            step_seen <= step_rise & test_mode;
            if (step_rise && test_mode) begin
                if (tour_pos == pet_state_pkg::tour_pos_t'(`PET_TOUR_LEN - 1)) begin
                    tour_pos <= '0;
                end else begin
                    tour_pos <= tour_pos + 1'b1;
                end
            end
        end
    end

endmodule
